// File: common/polycore_config.svh
`ifndef POLYCORE_CONFIG_SVH
`define POLYCORE_CONFIG_SVH

// Processing units sharing the external bus
`define POLY_UNITS	4

// Data and address width
`define BUS_W	16
// Command bits, 0 read, 1 write, 2 byte
`define BCMD_W	3

// Region field at the top of an address and the value that selects the TCM
`define REGION_W	4
`define TCM_REGION	{`REGION_W{1'b1}}

// Iram word address bits
`define IRAM_AW	8

`endif

// File: common/polycore_pkg.sv
`include "polycore_config.svh"

package polycore_pkg;

	// Split view of a CPU address
	typedef struct packed {
		logic	[`REGION_W-1:0]	region;	// Target select
		logic	[`BUS_W-`REGION_W-1:0]	offset;	// Bit 0 is the byte lane
	} bus_addr_s;

	// One address word, read flat by the bus and split by the units
	typedef union packed {
		logic	[`BUS_W-1:0]	word;
		bus_addr_s	split;
	} bus_addr_u;

endpackage

// File: punit/punit_iram.sv
`timescale 1ns/1ns
`include "polycore_config.svh"

module punit_iram (
	input	logic	clk,
	input	logic	iram_we_i,
	input	logic	iram_byte_i,	// Write one byte lane only
	input	polycore_pkg::bus_addr_u	badr_i,
	input	logic	[`BUS_W-1:0]	bdatw_i,
	output	logic	[`BUS_W-1:0]	bdatr_o
);

localparam int WORDS = 2 ** `IRAM_AW;

logic	[`BUS_W-1:0]	mem	[WORDS];
logic	[`IRAM_AW-1:0]	widx;
logic	lane_hi;

// Offset bit 0 is the lane, the bits above it the word; upper offset bits alias
assign	widx = badr_i.split.offset[`IRAM_AW:1];
assign	lane_hi = badr_i.split.offset[0];

always_ff @(posedge clk) begin
	if (iram_we_i) begin
		if (!iram_byte_i) begin
			mem[widx] <= bdatw_i;
		end else if (lane_hi) begin
			mem[widx][`BUS_W-1:`BUS_W-8] <= bdatw_i[7:0];	// High lane
		end else begin
			mem[widx][7:0] <= bdatw_i[7:0];	// Low lane
		end
	end
	bdatr_o <= mem[widx];	// Registered read, old data on a write
end

endmodule

// File: punit/punit_tcmc.sv
`timescale 1ns/1ns
`include "polycore_config.svh"

module punit_tcmc (
	input	logic	clk,
	input	logic	reset_i,
	// CPU side
	input	logic	[`BCMD_W-1:0]	cpu_bcmd_i,	// Read, write, byte
	input	polycore_pkg::bus_addr_u	cpu_badr_i,
	input	logic	[`BUS_W-1:0]	cpu_bdatw_i,
	// Shared bus side, through the arbiter
	input	logic	ext_brdy_i,
	input	logic	[`BUS_W-1:0]	ext_bdatr_i,
	// Local iram
	input	logic	[`BUS_W-1:0]	iram_bdatr_i,
	output	logic	cpu_brdy_o,
	output	logic	[`BUS_W-1:0]	cpu_bdatr_o,
	output	logic	ext_req_o,
	output	logic	[`BCMD_W-1:0]	ext_bcmd_o,
	output	polycore_pkg::bus_addr_u	ext_badr_o,
	output	logic	[`BUS_W-1:0]	ext_bdatw_o,
	output	logic	iram_we_o,
	output	logic	iram_byte_o
);

logic	cmd_rd;
logic	cmd_wr;
logic	cmd_byte;
logic	cmd_any;
logic	is_tcm;
logic	tcm_acc;
logic	tcm_busy;

// Command decode
assign	cmd_rd = cpu_bcmd_i[0];
assign	cmd_wr = cpu_bcmd_i[1];
assign	cmd_byte = cpu_bcmd_i[2];	// Size qualifier only
assign	cmd_any = cmd_rd | cmd_wr;

// Region decode on the split view
assign	is_tcm = (cpu_badr_i.split.region == `TCM_REGION);
assign	tcm_acc = cmd_any & is_tcm;

// A local access takes the command cycle plus one ready cycle.
// The flag blocks a second write while the command is still held.
always_ff @(posedge clk) begin
	if (reset_i) begin
		tcm_busy <= 1'b0;
	end else begin
		tcm_busy <= tcm_acc & ~tcm_busy;	// High only in the ready cycle
	end
end

// Iram strobes
assign	iram_we_o = tcm_acc & cmd_wr & ~tcm_busy;	// First cycle only
assign	iram_byte_o = cmd_byte;

// Anything outside the TCM goes to the shared bus
assign	ext_req_o = cmd_any & ~is_tcm;	// Level until ready
assign	ext_bcmd_o = ext_req_o ? cpu_bcmd_i : '0;
assign	ext_badr_o = cpu_badr_i;
assign	ext_bdatw_o = cpu_bdatw_i;

// Ready and read data back to the CPU
assign	cpu_brdy_o = tcm_busy | ext_brdy_i;
assign	cpu_bdatr_o = tcm_busy ? iram_bdatr_i : ext_bdatr_i;	// Local wins in its slot

// One ready per command, local or through the arbiter
brdy_once: assert property (
	@(posedge clk) disable iff (reset_i)
	cpu_brdy_o |=> !(cpu_brdy_o && $stable(cpu_bcmd_i) && $stable(cpu_badr_i))
) else $error("punit_tcmc: cpu_brdy_o repeated for a held command");

endmodule

// File: verilog/bus_arbiter.sv
`timescale 1ns/1ns
`include "polycore_config.svh"

module bus_arbiter #(
	parameter int UNITS = `POLY_UNITS
) (
	input	logic	clk,
	input	logic	reset_i,
	// Unit requests
	input	logic	[UNITS-1:0]	req_i,
	input	logic	[UNITS-1:0][`BCMD_W-1:0]	bcmd_i,
	input	polycore_pkg::bus_addr_u	[UNITS-1:0]	badr_i,
	input	logic	[UNITS-1:0][`BUS_W-1:0]	bdatw_i,
	// External memory bus
	input	logic	brdy_i,
	input	logic	[`BUS_W-1:0]	bdatr_i,
	output	logic	[UNITS-1:0]	brdy_o,
	output	logic	[`BUS_W-1:0]	bdatr_o,
	output	logic	[`BCMD_W-1:0]	bcmd_o,
	output	logic	[`BUS_W-1:0]	badr_o,
	output	logic	[`BUS_W-1:0]	bdatw_o
);

import polycore_pkg::*;

localparam int PTR_W = (UNITS > 1) ? $clog2(UNITS) : 1;

logic	[UNITS-1:0]	grant;	// One-hot owner of the bus
logic	[PTR_W-1:0]	ptr;	// Last unit granted
logic	[UNITS-1:0]	cand;
logic	[UNITS-1:0]	next_grant;
logic	[PTR_W-1:0]	next_ptr;
logic	next_valid;
logic	advance;
bus_addr_u	badr_sel;

// The holder is masked out so a completing unit cannot win on its own edge
assign	cand = req_i & ~grant;

// Grant changes when the bus is idle or the current access completes
assign	advance = (grant == '0) | brdy_i;

// Round-robin search starting after the last granted unit
always_comb begin
	int	idx;
	next_grant = '0;
	next_ptr = ptr;
	next_valid = 1'b0;
	for (int i = 1; i <= UNITS; i++) begin
		idx = (int'(ptr) + i) % UNITS;
		if (!next_valid && cand[idx]) begin
			next_grant[idx] = 1'b1;
			next_ptr = PTR_W'(idx);
			next_valid = 1'b1;
		end
	end
end

always_ff @(posedge clk) begin
	if (reset_i) begin
		grant <= '0;
		ptr <= PTR_W'(UNITS - 1);	// Unit 0 is first in line
	end else if (advance) begin
		grant <= next_grant;
		ptr <= next_ptr;	// Unchanged when nobody wins
	end
end

// AND-OR mux of the owner's command, address and data
always_comb begin
	bcmd_o = '0;
	badr_sel = '0;
	bdatw_o = '0;
	for (int u = 0; u < UNITS; u++) begin
		bcmd_o = bcmd_o | (bcmd_i[u] & {`BCMD_W{grant[u]}});
		badr_sel.word = badr_sel.word | (badr_i[u].word & {`BUS_W{grant[u]}});
		bdatw_o = bdatw_o | (bdatw_i[u] & {`BUS_W{grant[u]}});
	end
end

assign	badr_o = badr_sel.word;	// Forwarded as issued

// Ready goes to the owner only; read data is shared and qualified by ready
assign	brdy_o = grant & {UNITS{brdy_i}};
assign	bdatr_o = bdatr_i;

grant_onehot: assert property (
	@(posedge clk) disable iff (reset_i)
	$onehot0(grant)
) else $error("bus_arbiter: more than one unit granted");

// Holds only if the owning unit keeps its request stable until ready
bus_hold: assert property (
	@(posedge clk) disable iff (reset_i)
	(bcmd_o != '0 && !brdy_i) |=>
		($stable(bcmd_o) && $stable(badr_o) && $stable(bdatw_o))
) else $error("bus_arbiter: bus outputs changed while waiting for brdy_i");

endmodule

// File: verilog/polycore.sv
`timescale 1ns/1ns
`include "polycore_config.svh"

module polycore (
	input	logic	clk,
	input	logic	reset_i,
	// CPU buses, one per unit
	input	logic	[`POLY_UNITS-1:0][`BCMD_W-1:0]	cpu_bcmd_i,
	input	polycore_pkg::bus_addr_u	[`POLY_UNITS-1:0]	cpu_badr_i,
	input	logic	[`POLY_UNITS-1:0][`BUS_W-1:0]	cpu_bdatw_i,
	output	logic	[`POLY_UNITS-1:0]	cpu_brdy_o,
	output	logic	[`POLY_UNITS-1:0][`BUS_W-1:0]	cpu_bdatr_o,
	// Shared external memory bus
	input	logic	brdy_i,
	input	logic	[`BUS_W-1:0]	bdatr_i,
	output	logic	[`BCMD_W-1:0]	bcmd_o,
	output	logic	[`BUS_W-1:0]	badr_o,
	output	logic	[`BUS_W-1:0]	bdatw_o
);

import polycore_pkg::*;

logic	[`POLY_UNITS-1:0]	ext_req;
logic	[`POLY_UNITS-1:0][`BCMD_W-1:0]	ext_bcmd;
bus_addr_u	[`POLY_UNITS-1:0]	ext_badr;
logic	[`POLY_UNITS-1:0][`BUS_W-1:0]	ext_bdatw;
logic	[`POLY_UNITS-1:0]	ext_brdy;
logic	[`BUS_W-1:0]	ext_bdatr;	// Shared by all units
logic	[`POLY_UNITS-1:0]	iram_we;
logic	[`POLY_UNITS-1:0]	iram_byte;
logic	[`POLY_UNITS-1:0][`BUS_W-1:0]	iram_bdatr;

// Each unit has its own controller and local RAM
generate
	for (genvar u = 0; u < `POLY_UNITS; u++) begin : g_unit
		punit_tcmc tcmc (
			.clk(clk),
			.reset_i(reset_i),
			.cpu_bcmd_i(cpu_bcmd_i[u]),
			.cpu_badr_i(cpu_badr_i[u]),
			.cpu_bdatw_i(cpu_bdatw_i[u]),
			.ext_brdy_i(ext_brdy[u]),
			.ext_bdatr_i(ext_bdatr),
			.iram_bdatr_i(iram_bdatr[u]),
			.cpu_brdy_o(cpu_brdy_o[u]),
			.cpu_bdatr_o(cpu_bdatr_o[u]),
			.ext_req_o(ext_req[u]),
			.ext_bcmd_o(ext_bcmd[u]),
			.ext_badr_o(ext_badr[u]),
			.ext_bdatw_o(ext_bdatw[u]),
			.iram_we_o(iram_we[u]),
			.iram_byte_o(iram_byte[u])
		);

		punit_iram iram (
			.clk(clk),
			.iram_we_i(iram_we[u]),
			.iram_byte_i(iram_byte[u]),
			.badr_i(cpu_badr_i[u]),	// Address straight from the CPU
			.bdatw_i(cpu_bdatw_i[u]),
			.bdatr_o(iram_bdatr[u])
		);
	end
endgenerate

// Memory bus arbiter
bus_arbiter #(
	.UNITS(`POLY_UNITS)
) busa (
	.clk(clk),
	.reset_i(reset_i),
	.req_i(ext_req),
	.bcmd_i(ext_bcmd),
	.badr_i(ext_badr),
	.bdatw_i(ext_bdatw),
	.brdy_i(brdy_i),
	.bdatr_i(bdatr_i),
	.brdy_o(ext_brdy),
	.bdatr_o(ext_bdatr),
	.bcmd_o(bcmd_o),
	.badr_o(badr_o),
	.bdatw_o(bdatw_o)
);

endmodule

// File: verif/polycore_tb.sv
`timescale 1ns/1ns
`include "polycore_config.svh"

module polycore_tb;

import polycore_pkg::*;

localparam int U = `POLY_UNITS;
localparam int N_RAND = 40;	// Random accesses per unit
localparam int N_FAIR = 4;	// External reads per unit in the contention round
localparam int TIMEOUT = 6000;	// Well above init, random and contention phases together

logic	clk;
logic	reset_i;
logic	[U-1:0][`BCMD_W-1:0]	cpu_bcmd_i;
bus_addr_u	[U-1:0]	cpu_badr_i;
logic	[U-1:0][`BUS_W-1:0]	cpu_bdatw_i;
logic	[U-1:0]	cpu_brdy_o;
logic	[U-1:0][`BUS_W-1:0]	cpu_bdatr_o;
logic	brdy_i;
logic	[`BUS_W-1:0]	bdatr_i;
logic	[`BCMD_W-1:0]	bcmd_o;
logic	[`BUS_W-1:0]	badr_o;
logic	[`BUS_W-1:0]	bdatw_o;

int	seed = 84;
int	cycles = 0;
logic	[`BUS_W-1:0]	shadow	[U][8];	// Iram model, words 0 to 7
logic	[U-1:0]	first;	// Command is in its first cycle
logic	[U-1:0]	cur_tcm;
logic	[U-1:0]	rd_chk;
logic	[U-1:0][`BUS_W-1:0]	exp_rd;
logic	started;
logic	fair_phase;
int	ext_done	[U] = '{default: 0};
int	min_done;
logic	fair_ok;
logic	hold_prev;
logic	[`BCMD_W-1:0]	prev_bcmd;
logic	[`BUS_W-1:0]	prev_badr;
logic	[`BUS_W-1:0]	prev_bdatw;
logic	waiting;
int	wait_left;

polycore dut_i (
	.clk(clk),
	.reset_i(reset_i),
	.cpu_bcmd_i(cpu_bcmd_i),
	.cpu_badr_i(cpu_badr_i),
	.cpu_bdatw_i(cpu_bdatw_i),
	.cpu_brdy_o(cpu_brdy_o),
	.cpu_bdatr_o(cpu_bdatr_o),
	.brdy_i(brdy_i),
	.bdatr_i(bdatr_i),
	.bcmd_o(bcmd_o),
	.badr_o(badr_o),
	.bdatw_o(bdatw_o)
);

initial begin
	clk = 1'b0;
	forever #50 clk = ~clk;
end

task automatic value_error(string name, logic [`BUS_W-1:0] exp, logic [`BUS_W-1:0] act);
	$display("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
	$display("test failed");
	$fatal(1);
endtask

task automatic plain_error(string what);
	$display("%s at %0t", what, $time);
	$display("test failed");
	$fatal(1);
endtask

// Drive one access and wait for its ready; the command is held through the ready cycle
task automatic issue(int u, logic [`BCMD_W-1:0] cmd, logic [`BUS_W-1:0] addr,
		logic [`BUS_W-1:0] data);
	bus_addr_u	a;
	int	w;
	a.word = addr;
	w = a.split.offset[3:1];
	@(negedge clk);
	cpu_bcmd_i[u] = cmd;
	cpu_badr_i[u] = a;
	cpu_bdatw_i[u] = data;
	first[u] = 1'b1;
	cur_tcm[u] = (a.split.region == `TCM_REGION);
	rd_chk[u] = cmd[0];
	if (!cur_tcm[u]) begin
		exp_rd[u] = addr ^ 16'ha5c3;	// Responder rule
	end else if (cmd[0]) begin
		exp_rd[u] = shadow[u][w];
	end else if (!cmd[2]) begin
		shadow[u][w] = data;
	end else if (a.split.offset[0]) begin
		shadow[u][w][15:8] = data[7:0];
	end else begin
		shadow[u][w][7:0] = data[7:0];
	end
	@(negedge clk);
	first[u] = 1'b0;
	#10;
	while (!cpu_brdy_o[u]) begin
		@(negedge clk);
		#10;
	end
endtask

task automatic drop(int u);
	@(negedge clk);
	cpu_bcmd_i[u] = '0;
endtask

task automatic rand_access(int u);
	logic	[31:0]	r;
	logic	[`BUS_W-1:0]	data;
	logic	[`BUS_W-1:0]	addr;
	logic	[`BCMD_W-1:0]	cmd;
	r = $random(seed);
	data = $random(seed);
	if (r[0]) begin
		// Upper offset bits alias onto the same word
		addr = {4'hf, r[10:8], 5'b0, r[6:4], r[7]};
		case (r[2:1])
			2'd1: cmd = 3'b010;
			2'd2: cmd = 3'b110;	// Byte write
			default: cmd = 3'b001;
		endcase
	end else begin
		addr = {4'(u), r[27:16]};	// Region names the unit
		cmd = r[1] ? 3'b010 : 3'b001;
	end
	issue(u, cmd, addr, data);
endtask

task automatic run_unit(int u);
	for (int w = 0; w < 8; w++) begin
		issue(u, 3'b010, {4'hf, 8'h0, 3'(w), 1'b0}, {4'(u), 4'(w), 8'(w * 37)});
	end
	for (int i = 0; i < N_RAND; i++) begin
		rand_access(u);
	end
	drop(u);
endtask

task automatic fair_unit(int u);
	for (int i = 0; i < N_FAIR; i++) begin
		issue(u, 3'b001, {4'(u), 12'(i * 16 + 3)}, '0);
	end
	drop(u);
endtask

// External memory with a random wait of 0 to 3 cycles
initial begin
	waiting = 1'b0;
	wait_left = 0;
	forever begin
		@(negedge clk);
		brdy_i = 1'b0;
		if (!reset_i && bcmd_o != '0) begin
			if (!waiting) begin
				waiting = 1'b1;
				wait_left = $unsigned($random(seed)) % 4;
			end
			if (wait_left == 0) begin
				brdy_i = 1'b1;
				bdatr_i = badr_o ^ 16'ha5c3;
				waiting = 1'b0;
			end else begin
				wait_left--;
			end
		end
	end
end

always_comb begin
	min_done = ext_done[0];
	for (int u = 1; u < U; u++) begin
		if (ext_done[u] < min_done) min_done = ext_done[u];
	end
	fair_ok = (ext_done[badr_o[13:12]] == min_done);
end

always @(posedge clk) begin
	if (fair_phase && brdy_i && bcmd_o != '0) begin
		ext_done[badr_o[13:12]] <= ext_done[badr_o[13:12]] + 1;
	end
	hold_prev <= !reset_i && bcmd_o != '0 && !brdy_i;
	prev_bcmd <= bcmd_o;
	prev_badr <= badr_o;
	prev_bdatw <= bdatw_o;
	cycles <= cycles + 1;
	if (cycles >= TIMEOUT) plain_error("Timeout, the accesses did not finish in time");
end

idle_after_reset: assert property (@(posedge clk) disable iff (reset_i)
	!started |-> (cpu_brdy_o == '0 && bcmd_o == '0)
) else plain_error("Ready or bus command seen before any command was driven");

bus_region: assert property (@(posedge clk) disable iff (reset_i)
	bcmd_o != '0 |-> badr_o[15:12] < U
) else plain_error("A local TCM access appeared on the external bus");

bus_hold_addr: assert property (@(posedge clk) hold_prev |-> badr_o == prev_badr)
	else value_error("badr_o", $sampled(prev_badr), $sampled(badr_o));
bus_hold_data: assert property (@(posedge clk) hold_prev |-> bdatw_o == prev_bdatw)
	else value_error("bdatw_o", $sampled(prev_bdatw), $sampled(bdatw_o));
bus_hold_cmd: assert property (@(posedge clk) hold_prev |-> bcmd_o == prev_bcmd)
	else value_error("bcmd_o", $sampled(prev_bcmd), $sampled(bcmd_o));

round_robin: assert property (@(posedge clk) disable iff (reset_i)
	(fair_phase && brdy_i) |-> fair_ok
) else value_error("completions of owner", $sampled(min_done),
	$sampled(ext_done[badr_o[13:12]]));

generate
	for (genvar u = 0; u < U; u++) begin : g_chk
		tcm_latency: assert property (@(posedge clk) disable iff (reset_i)
			(first[u] && cur_tcm[u]) |=> cpu_brdy_o[u]
		) else value_error($sformatf("cpu_brdy_o[%0d]", u), 1, 0);

		ready_source: assert property (@(posedge clk) disable iff (reset_i)
			cpu_brdy_o[u] |-> ((brdy_i && badr_o[15:12] == u) || $past(first[u] && cur_tcm[u]))
		) else plain_error($sformatf("Unexpected ready on unit %0d", u));

		read_data: assert property (@(posedge clk) disable iff (reset_i)
			(cpu_brdy_o[u] && rd_chk[u]) |-> cpu_bdatr_o[u] == exp_rd[u]
		) else value_error($sformatf("cpu_bdatr_o[%0d]", u), exp_rd[u], $sampled(cpu_bdatr_o[u]));

		bus_match_cmd: assert property (@(posedge clk) disable iff (reset_i)
			(bcmd_o != '0 && badr_o[15:12] == u) |-> bcmd_o == cpu_bcmd_i[u]
		) else value_error("bcmd_o", $sampled(cpu_bcmd_i[u]), $sampled(bcmd_o));

		bus_match_addr: assert property (@(posedge clk) disable iff (reset_i)
			(bcmd_o != '0 && badr_o[15:12] == u) |-> badr_o == cpu_badr_i[u].word
		) else value_error("badr_o", $sampled(cpu_badr_i[u].word), $sampled(badr_o));

		bus_match_data: assert property (@(posedge clk) disable iff (reset_i)
			(bcmd_o != '0 && badr_o[15:12] == u) |-> bdatw_o == cpu_bdatw_i[u]
		) else value_error("bdatw_o", $sampled(cpu_bdatw_i[u]), $sampled(bdatw_o));
	end
endgenerate

initial begin
	reset_i = 1'b1;
	cpu_bcmd_i = '0;
	cpu_badr_i = '0;
	cpu_bdatw_i = '0;
	brdy_i = 1'b0;
	bdatr_i = '0;
	first = '0;
	cur_tcm = '0;
	rd_chk = '0;
	exp_rd = '0;
	started = 1'b0;
	fair_phase = 1'b0;
	repeat (16) @(negedge clk);
	reset_i = 1'b0;
	repeat (3) @(negedge clk);
	started = 1'b1;
	for (int u = 0; u < U; u++) begin
		fork
			automatic int k = u;
			run_unit(k);
		join_none
	end
	wait fork;
	repeat (4) @(negedge clk);
	fair_phase = 1'b1;
	for (int u = 0; u < U; u++) begin
		fork
			automatic int k = u;
			fair_unit(k);
		join_none
	end
	wait fork;
	fair_phase = 1'b0;
	repeat (4) @(negedge clk);
	$display("test passed");
	$finish;
end

endmodule

// File: polycore.f
+incdir+common
common/polycore_pkg.sv
punit/punit_iram.sv
punit/punit_tcmc.sv
verilog/bus_arbiter.sv
verilog/polycore.sv
verif/polycore_tb.sv
